// ==== sim.f ====
verilog/img_sel_pkg.sv
verilog/wb_reg_pkg.sv
verilog/img_stream_if.sv
verilog/img_selector_regs.sv
verilog/img_selector_core.sv
verilog/img_selector_top.sv
testbench/tb_img_selector.sv

// ==== testbench/tb_img_selector.sv ====
/*
 * Testbench for the video source selector.
 * Drives random small frames on every input, steers the source over
 * Wishbone and checks each output beat against a cycle model.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_img_selector;

    localparam int FIXED_BEATS  = 300;
    localparam int CKE_BEATS    = 300;
    localparam int SWITCH_LIMIT = 100;
    localparam int TEST_BEATS   = FIXED_BEATS + CKE_BEATS + 4 * SWITCH_LIMIT;
    localparam int BUS_OPS      = 32 + 2 * SWITCH_LIMIT;
    localparam longint WATCHDOG_NS = longint'(TEST_BEATS + BUS_OPS) * 2 * 100;

    logic clk;
    logic rst;
    logic cke;

    logic [img_sel_pkg::NUM-1:0]                              s_row_first;
    logic [img_sel_pkg::NUM-1:0]                              s_row_last;
    logic [img_sel_pkg::NUM-1:0]                              s_col_first;
    logic [img_sel_pkg::NUM-1:0]                              s_col_last;
    logic [img_sel_pkg::NUM-1:0]                              s_de;
    logic [img_sel_pkg::NUM-1:0][img_sel_pkg::USER_WIDTH-1:0] s_user;
    logic [img_sel_pkg::NUM-1:0][img_sel_pkg::DATA_WIDTH-1:0] s_data;
    logic [img_sel_pkg::NUM-1:0]                              s_valid;

    logic                               m_row_first;
    logic                               m_row_last;
    logic                               m_col_first;
    logic                               m_col_last;
    logic                               m_de;
    logic [img_sel_pkg::USER_WIDTH-1:0] m_user;
    logic [img_sel_pkg::DATA_WIDTH-1:0] m_data;
    logic                               m_valid;

    logic [wb_reg_pkg::WB_ADR_WIDTH-1:0] wb_adr;
    logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] wb_dat;
    logic [wb_reg_pkg::WB_SEL_WIDTH-1:0] wb_sel;
    logic                                wb_we;
    logic                                wb_stb;
    logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] wb_dat_o;
    logic                                wb_ack;

    // model state
    logic [img_sel_pkg::SEL_WIDTH-1:0]  model_ctl;
    logic [img_sel_pkg::SEL_WIDTH-1:0]  model_applied;
    logic                               exp_valid;
    logic                               exp_de;
    logic [3:0]                         exp_flags;
    logic [img_sel_pkg::USER_WIDTH-1:0] exp_user;
    logic [img_sel_pkg::DATA_WIDTH-1:0] exp_data;

    // frame generators, one per input
    int gen_col [img_sel_pkg::NUM];
    int gen_row [img_sel_pkg::NUM];
    int gen_w   [img_sel_pkg::NUM];
    int gen_h   [img_sel_pkg::NUM];

    integer seed;
    int     error_count;
    logic   cke_random;
    string  test_name;

    img_selector_top dut0 (
        .s_wb_clk_i        (clk),
        .s_wb_rst_i        (rst),
        .cke_i             (cke),
        .s_img_row_first_i (s_row_first),
        .s_img_row_last_i  (s_row_last),
        .s_img_col_first_i (s_col_first),
        .s_img_col_last_i  (s_col_last),
        .s_img_de_i        (s_de),
        .s_img_user_i      (s_user),
        .s_img_data_i      (s_data),
        .s_img_valid_i     (s_valid),
        .m_img_row_first_o (m_row_first),
        .m_img_row_last_o  (m_row_last),
        .m_img_col_first_o (m_col_first),
        .m_img_col_last_o  (m_col_last),
        .m_img_de_o        (m_de),
        .m_img_user_o      (m_user),
        .m_img_data_o      (m_data),
        .m_img_valid_o     (m_valid),
        .s_wb_adr_i        (wb_adr),
        .s_wb_dat_i        (wb_dat),
        .s_wb_sel_i        (wb_sel),
        .s_wb_we_i         (wb_we),
        .s_wb_stb_i        (wb_stb),
        .s_wb_dat_o        (wb_dat_o),
        .s_wb_ack_o        (wb_ack)
    );

    always #50 clk = ~clk;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s: %s expected %h actual %h", test_name, what,
                     expected, actual);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic new_frame_size(input int i);
        gen_w[i] = 4 + {$random(seed)} % 5;
        gen_h[i] = 2 + {$random(seed)} % 3;
    endtask

    task automatic next_beat(input int i);
        logic [31:0] rnd;
        rnd = $random(seed);
        s_valid[i]     = (rnd[2:0] != 3'd0);
        // some valid beats are blanking, de low
        s_de[i]        = s_valid[i] && (rnd[4:3] != 2'd0);
        s_row_first[i] = s_de[i] && (gen_row[i] == 0);
        s_row_last[i]  = s_de[i] && (gen_row[i] == gen_h[i] - 1);
        s_col_first[i] = s_de[i] && (gen_col[i] == 0);
        s_col_last[i]  = s_de[i] && (gen_col[i] == gen_w[i] - 1);
        rnd = $random(seed);
        s_user[i] = s_valid[i] ? rnd[31:31-img_sel_pkg::USER_WIDTH+1] : '0;
        s_data[i] = s_valid[i] ? rnd[img_sel_pkg::DATA_WIDTH-1:0] : '0;
        if (s_de[i]) begin
            if (gen_col[i] == gen_w[i] - 1) begin
                gen_col[i] = 0;
                if (gen_row[i] == gen_h[i] - 1) begin
                    gen_row[i] = 0;
                    new_frame_size(i);
                end else begin
                    gen_row[i]++;
                end
            end else begin
                gen_col[i]++;
            end
        end
    endtask

    // a beat moves on only once the DUT has taken it
    task automatic drive_streams();
        if (cke) begin
            for (int i = 0; i < img_sel_pkg::NUM; i++) begin
                next_beat(i);
            end
        end
        cke = cke_random ? (({$random(seed)} % 10) != 0) : 1'b1;
    endtask

    // ------------------------------------------------------------------
    // reference model, evaluated with the values present before an edge
    // ------------------------------------------------------------------
    task automatic predict_edge();
        logic [img_sel_pkg::SEL_WIDTH-1:0]  src;
        logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] word;
        if (rst) begin
            exp_valid     = 1'b0;
            exp_de        = 1'b0;
            model_ctl     = img_sel_pkg::INIT_SELECT;
            model_applied = img_sel_pkg::INIT_SELECT;
        end else begin
            if (cke) begin
                src = model_applied;
                if (s_valid[model_ctl] && s_de[model_ctl] && s_row_first[model_ctl]
                        && s_col_first[model_ctl]) begin
                    src = model_ctl;
                end
                model_applied = src;
                exp_valid = s_valid[src];
                exp_de    = s_de[src];
                exp_flags = {s_row_first[src], s_row_last[src], s_col_first[src], s_col_last[src]};
                exp_user  = s_user[src];
                exp_data  = s_data[src];
            end
            if (wb_stb && wb_we && wb_adr == wb_reg_pkg::ADR_CTL_SELECT) begin
                word = 32'(model_ctl);
                for (int lane = 0; lane < wb_reg_pkg::WB_SEL_WIDTH; lane++) begin
                    if (wb_sel[lane]) begin
                        word[lane*8 +: 8] = wb_dat[lane*8 +: 8];
                    end
                end
                model_ctl = word[img_sel_pkg::SEL_WIDTH-1:0];
            end
        end
    endtask

    task automatic check_outputs();
        compare_value("valid", 32'(exp_valid), 32'(m_valid));
        compare_value("de", 32'(exp_de), 32'(m_de));
        if (exp_valid) begin
            compare_value("flags", 32'(exp_flags),
                          32'({m_row_first, m_row_last, m_col_first, m_col_last}));
            compare_value("user", 32'(exp_user), 32'(m_user));
            compare_value("data", 32'(exp_data), 32'(m_data));
        end
    endtask

    // one clock cycle, entered and left 10 ns after a rising edge
    task automatic tick();
        predict_edge();
        @(posedge clk);
        #10;
        check_outputs();
        drive_streams();
    endtask

    task automatic run_cycles(input int n);
        repeat (n) tick();
    endtask

    // ------------------------------------------------------------------
    // Wishbone tasks
    // ------------------------------------------------------------------
    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        wb_adr = adr;
        wb_dat = dat;
        wb_sel = sel;
        wb_we  = 1'b1;
        wb_stb = 1'b1;
        #20;
        compare_value("wb write ack", 32'd1, 32'(wb_ack));
        tick();
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        #20;
        dat = wb_dat_o;
        compare_value("wb read ack", 32'd1, 32'(wb_ack));
        tick();
        wb_stb = 1'b0;
    endtask

    task automatic read_expect(input string what, input logic [7:0] adr,
                               input logic [31:0] expected);
        logic [31:0] rd;
        wb_read(adr, rd);
        compare_value(what, expected, rd);
    endtask

    // request a new source mid frame and follow the status until it moves
    task automatic switch_source(input logic [img_sel_pkg::SEL_WIDTH-1:0] new_sel);
        logic [31:0] rd;
        logic [31:0] exp_sts;
        int          guard;
        guard = 0;
        while (gen_row[model_applied] == 0 && guard < SWITCH_LIMIT) begin
            tick();
            guard++;
        end
        wb_write(wb_reg_pkg::ADR_CTL_SELECT, 32'(new_sel), 4'hf);
        guard = 0;
        do begin
            exp_sts = 32'(model_applied);
            wb_read(wb_reg_pkg::ADR_STS_SELECT, rd);
            compare_value("status", exp_sts, rd);
            guard++;
        end while (rd != 32'(new_sel) && guard < SWITCH_LIMIT);
        compare_value("final status", 32'(new_sel), rd);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run timed out");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed        = 32'h9e36_5850;
        error_count = 0;
        cke_random  = 1'b0;
        clk         = 1'b0;
        rst         = 1'b1;
        cke         = 1'b1;
        s_row_first = '0;
        s_row_last  = '0;
        s_col_first = '0;
        s_col_last  = '0;
        s_de        = '0;
        s_user      = '0;
        s_data      = '0;
        s_valid     = '0;
        wb_adr      = '0;
        wb_dat      = '0;
        wb_sel      = '0;
        wb_we       = 1'b0;
        wb_stb      = 1'b0;
        for (int i = 0; i < img_sel_pkg::NUM; i++) begin
            gen_col[i] = 0;
            gen_row[i] = 0;
            new_frame_size(i);
        end

        test_name = "reset";
        run_cycles(4);
        rst = 1'b0;

        test_name = "registers";
        read_expect("core id", wb_reg_pkg::ADR_CORE_ID, wb_reg_pkg::CORE_ID);
        read_expect("core version", wb_reg_pkg::ADR_CORE_VERSION, wb_reg_pkg::CORE_VERSION);
        read_expect("config num", wb_reg_pkg::ADR_CONFIG_NUM, 32'd2);
        read_expect("ctl after reset", wb_reg_pkg::ADR_CTL_SELECT, 32'(img_sel_pkg::INIT_SELECT));
        read_expect("sts after reset", wb_reg_pkg::ADR_STS_SELECT, 32'(img_sel_pkg::INIT_SELECT));
        read_expect("unknown 0x02", 8'h02, 32'd0);
        read_expect("unknown 0x0a", 8'h0a, 32'd0);
        read_expect("unknown 0xff", 8'hff, 32'd0);

        test_name = "byte lanes";
        wb_write(wb_reg_pkg::ADR_CTL_SELECT, 32'hffff_ff01, 4'b1110);
        read_expect("ctl lane 0 off", wb_reg_pkg::ADR_CTL_SELECT, 32'(img_sel_pkg::INIT_SELECT));
        wb_write(wb_reg_pkg::ADR_CTL_SELECT, 32'hffff_fff1, 4'b0001);
        read_expect("ctl lane 0 on", wb_reg_pkg::ADR_CTL_SELECT, 32'd1);
        wb_write(wb_reg_pkg::ADR_CTL_SELECT, 32'h0000_0000, 4'b0001);
        read_expect("ctl cleared", wb_reg_pkg::ADR_CTL_SELECT, 32'd0);

        test_name = "fixed source";
        run_cycles(FIXED_BEATS);

        test_name = "switch to 1";
        switch_source(1'b1);
        run_cycles(40);
        test_name = "switch to 0";
        switch_source(1'b0);
        run_cycles(40);

        test_name = "clock enable";
        cke_random = 1'b1;
        run_cycles(CKE_BEATS);
        cke_random = 1'b0;
        run_cycles(4);

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/img_selector_top.sv ====
/*
 * Top level of the video source selector.
 * Plain stream ports are packed onto stream interfaces, then the
 * Wishbone register block and the switching core are connected.
 */

`timescale 1ns/100ps
`default_nettype none

module img_selector_top (
    input  logic                                                  s_wb_clk_i,
    input  logic                                                  s_wb_rst_i,
    input  logic                                                  cke_i,

    // input streams, one bit or one word per source
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_row_first_i,
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_row_last_i,
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_col_first_i,
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_col_last_i,
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_de_i,
    input  logic [img_sel_pkg::NUM-1:0][img_sel_pkg::USER_WIDTH-1:0] s_img_user_i,
    input  logic [img_sel_pkg::NUM-1:0][img_sel_pkg::DATA_WIDTH-1:0] s_img_data_i,
    input  logic [img_sel_pkg::NUM-1:0]                           s_img_valid_i,

    // selected output stream
    output logic                                                  m_img_row_first_o,
    output logic                                                  m_img_row_last_o,
    output logic                                                  m_img_col_first_o,
    output logic                                                  m_img_col_last_o,
    output logic                                                  m_img_de_o,
    output logic [img_sel_pkg::USER_WIDTH-1:0]                    m_img_user_o,
    output logic [img_sel_pkg::DATA_WIDTH-1:0]                    m_img_data_o,
    output logic                                                  m_img_valid_o,

    // Wishbone slave
    input  logic [wb_reg_pkg::WB_ADR_WIDTH-1:0]                   s_wb_adr_i,
    input  logic [wb_reg_pkg::WB_DAT_WIDTH-1:0]                   s_wb_dat_i,
    input  logic [wb_reg_pkg::WB_SEL_WIDTH-1:0]                   s_wb_sel_i,
    input  logic                                                  s_wb_we_i,
    input  logic                                                  s_wb_stb_i,
    output logic [wb_reg_pkg::WB_DAT_WIDTH-1:0]                   s_wb_dat_o,
    output logic                                                  s_wb_ack_o
);

    logic [img_sel_pkg::SEL_WIDTH-1:0] ctl_select;
    logic [img_sel_pkg::SEL_WIDTH-1:0] applied_select;

    img_stream_if s_img [img_sel_pkg::NUM] ();
    img_stream_if m_img ();

    // ------------------------------------------------------------------
    // plain ports onto the stream interfaces
    // ------------------------------------------------------------------
    for (genvar i = 0; i < img_sel_pkg::NUM; i++) begin : g_in
        assign s_img[i].row_first = s_img_row_first_i[i];
        assign s_img[i].row_last  = s_img_row_last_i[i];
        assign s_img[i].col_first = s_img_col_first_i[i];
        assign s_img[i].col_last  = s_img_col_last_i[i];
        assign s_img[i].de        = s_img_de_i[i];
        assign s_img[i].user      = s_img_user_i[i];
        assign s_img[i].data      = s_img_data_i[i];
        assign s_img[i].valid     = s_img_valid_i[i];
    end

    assign m_img_row_first_o = m_img.row_first;
    assign m_img_row_last_o  = m_img.row_last;
    assign m_img_col_first_o = m_img.col_first;
    assign m_img_col_last_o  = m_img.col_last;
    assign m_img_de_o        = m_img.de;
    assign m_img_user_o      = m_img.user;
    assign m_img_data_o      = m_img.data;
    assign m_img_valid_o     = m_img.valid;

    // ------------------------------------------------------------------
    // register block and core
    // ------------------------------------------------------------------
    img_selector_regs u_regs (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .s_wb_adr_i       (s_wb_adr_i),
        .s_wb_dat_i       (s_wb_dat_i),
        .s_wb_sel_i       (s_wb_sel_i),
        .s_wb_we_i        (s_wb_we_i),
        .s_wb_stb_i       (s_wb_stb_i),
        .s_wb_dat_o       (s_wb_dat_o),
        .s_wb_ack_o       (s_wb_ack_o),
        .applied_select_i (applied_select),
        .ctl_select_o     (ctl_select)
    );

    img_selector_core u_core (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .cke_i            (cke_i),
        .ctl_select_i     (ctl_select),
        .s_img            (s_img),
        .m_img            (m_img),
        .applied_select_o (applied_select)
    );

endmodule

`default_nettype wire

// ==== verilog/img_selector_core.sv ====
/*
 * Frame synchronous source switch with one registered output stage.
 * A requested source takes over only on its own frame start beat,
 * and that beat is already forwarded. Everything holds with cke_i low.
 */

`timescale 1ns/100ps
`default_nettype none

module img_selector_core (
    input  logic                               s_wb_clk_i,
    input  logic                               s_wb_rst_i,
    input  logic                               cke_i,
    input  logic [img_sel_pkg::SEL_WIDTH-1:0]  ctl_select_i,
    img_stream_if.sink                         s_img [img_sel_pkg::NUM],
    img_stream_if.source                       m_img,
    output logic [img_sel_pkg::SEL_WIDTH-1:0]  applied_select_o
);

    logic [img_sel_pkg::NUM-1:0]                              in_row_first;
    logic [img_sel_pkg::NUM-1:0]                              in_row_last;
    logic [img_sel_pkg::NUM-1:0]                              in_col_first;
    logic [img_sel_pkg::NUM-1:0]                              in_col_last;
    logic [img_sel_pkg::NUM-1:0]                              in_de;
    logic [img_sel_pkg::NUM-1:0][img_sel_pkg::USER_WIDTH-1:0] in_user;
    logic [img_sel_pkg::NUM-1:0][img_sel_pkg::DATA_WIDTH-1:0] in_data;
    logic [img_sel_pkg::NUM-1:0]                              in_valid;

    logic [img_sel_pkg::SEL_WIDTH-1:0] applied_sel;
    logic [img_sel_pkg::SEL_WIDTH-1:0] sel_now;
    logic                              frame_start;

    // ------------------------------------------------------------------
    // flatten the input streams so they can be indexed at run time
    // ------------------------------------------------------------------
    for (genvar i = 0; i < img_sel_pkg::NUM; i++) begin : g_flat
        assign in_row_first[i] = s_img[i].row_first;
        assign in_row_last[i]  = s_img[i].row_last;
        assign in_col_first[i] = s_img[i].col_first;
        assign in_col_last[i]  = s_img[i].col_last;
        assign in_de[i]        = s_img[i].de;
        assign in_user[i]      = s_img[i].user;
        assign in_data[i]      = s_img[i].data;
        assign in_valid[i]     = s_img[i].valid;
    end

    // ------------------------------------------------------------------
    // switch decision
    // ------------------------------------------------------------------
    // first beat of a frame on the requested input
    assign frame_start = in_valid[ctl_select_i]
                      && in_de[ctl_select_i]
                      && in_row_first[ctl_select_i]
                      && in_col_first[ctl_select_i];

    // the start beat itself comes from the new source
    assign sel_now = frame_start ? ctl_select_i : applied_sel;

    // control state and the qualifiers of the output beat
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            applied_sel <= img_sel_pkg::INIT_SELECT;
            m_img.valid <= 1'b0;
            m_img.de    <= 1'b0;
        end else if (cke_i) begin
            applied_sel <= sel_now;
            m_img.valid <= in_valid[sel_now];
            m_img.de    <= in_de[sel_now];
        end
    end

    // payload of the output beat
    always_ff @(posedge s_wb_clk_i) begin
        if (cke_i) begin
            m_img.row_first <= in_row_first[sel_now];
            m_img.row_last  <= in_row_last[sel_now];
            m_img.col_first <= in_col_first[sel_now];
            m_img.col_last  <= in_col_last[sel_now];
            m_img.user      <= in_user[sel_now];
            m_img.data      <= in_data[sel_now];
        end
    end

    assign applied_select_o = applied_sel;

endmodule

`default_nettype wire

// ==== verilog/img_selector_regs.sv ====
/*
 * Wishbone register block of the video source selector.
 * Holds the requested source and reports ID, version, input count
 * and the source in use. Ack follows strobe, so the bus never waits.
 */

`timescale 1ns/100ps
`default_nettype none

module img_selector_regs (
    input  logic                                   s_wb_clk_i,
    input  logic                                   s_wb_rst_i,
    input  logic [wb_reg_pkg::WB_ADR_WIDTH-1:0]    s_wb_adr_i,
    input  logic [wb_reg_pkg::WB_DAT_WIDTH-1:0]    s_wb_dat_i,
    input  logic [wb_reg_pkg::WB_SEL_WIDTH-1:0]    s_wb_sel_i,
    input  logic                                   s_wb_we_i,
    input  logic                                   s_wb_stb_i,
    output logic [wb_reg_pkg::WB_DAT_WIDTH-1:0]    s_wb_dat_o,
    output logic                                   s_wb_ack_o,
    input  logic [img_sel_pkg::SEL_WIDTH-1:0]      applied_select_i,
    output logic [img_sel_pkg::SEL_WIDTH-1:0]      ctl_select_o
);

    logic [img_sel_pkg::SEL_WIDTH-1:0]   ctl_select;
    logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] ctl_word;
    logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] ctl_word_next;

    // merge write data into an old word, one byte lane per sel bit
    function automatic logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] write_mask(
        input logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] old_word,
        input logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] wr_word,
        input logic [wb_reg_pkg::WB_SEL_WIDTH-1:0] lane_en
    );
        logic [wb_reg_pkg::WB_DAT_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < wb_reg_pkg::WB_DAT_WIDTH; b++) begin
            if (lane_en[b / 8]) begin
                merged[b] = wr_word[b];
            end
        end
        return merged;
    endfunction

    // ------------------------------------------------------------------
    // control register
    // ------------------------------------------------------------------
    assign ctl_word      = wb_reg_pkg::WB_DAT_WIDTH'(ctl_select);
    assign ctl_word_next = write_mask(ctl_word, s_wb_dat_i, s_wb_sel_i);

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            ctl_select <= img_sel_pkg::INIT_SELECT;
        end else if (s_wb_stb_i && s_wb_we_i) begin
            // only the control word is writable
            if (s_wb_adr_i == wb_reg_pkg::ADR_CTL_SELECT) begin
                ctl_select <= img_sel_pkg::SEL_WIDTH'(ctl_word_next);
            end
        end
    end

    assign ctl_select_o = ctl_select;

    // ------------------------------------------------------------------
    // read decode
    // ------------------------------------------------------------------
    always_comb begin
        s_wb_dat_o = '0;
        case (s_wb_adr_i)
            wb_reg_pkg::ADR_CORE_ID: begin
                s_wb_dat_o = wb_reg_pkg::CORE_ID;
            end
            wb_reg_pkg::ADR_CORE_VERSION: begin
                s_wb_dat_o = wb_reg_pkg::CORE_VERSION;
            end
            wb_reg_pkg::ADR_CTL_SELECT: begin
                s_wb_dat_o = ctl_word;
            end
            wb_reg_pkg::ADR_STS_SELECT: begin
                s_wb_dat_o = wb_reg_pkg::WB_DAT_WIDTH'(applied_select_i);
            end
            wb_reg_pkg::ADR_CONFIG_NUM: begin
                s_wb_dat_o = wb_reg_pkg::WB_DAT_WIDTH'(img_sel_pkg::NUM);
            end
            default: begin
                s_wb_dat_o = '0;
            end
        endcase
    end

    // single cycle transfers
    assign s_wb_ack_o = s_wb_stb_i;

endmodule

`default_nettype wire

// ==== verilog/img_stream_if.sv ====
/*
 * One raster stream with frame flags, data enable, user bits and data.
 * The source modport drives a stream and the sink modport takes it in.
 */

`timescale 1ns/100ps
`default_nettype none

interface img_stream_if ();

    logic                                row_first;
    logic                                row_last;
    logic                                col_first;
    logic                                col_last;
    logic                                de;
    logic [img_sel_pkg::USER_WIDTH-1:0]  user;
    logic [img_sel_pkg::DATA_WIDTH-1:0]  data;
    // beat present in this cycle
    logic                                valid;

    modport source (
        output row_first, row_last, col_first, col_last,
        output de, user, data, valid
    );

    modport sink (
        input  row_first, row_last, col_first, col_last,
        input  de, user, data, valid
    );

endinterface

`default_nettype wire

// ==== verilog/wb_reg_pkg.sv ====
/*
 * Wishbone side constants for the video source selector.
 * Bus widths, the register map and the identification words.
 */

`default_nettype none

package wb_reg_pkg;

    // bus widths
    localparam int WB_ADR_WIDTH = 8;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;

    // ------------------------------------------------------------------
    // register map, word addresses
    // ------------------------------------------------------------------
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CORE_ID      = 8'h00;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CORE_VERSION = 8'h01;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CTL_SELECT   = 8'h08;
    // read only, the source actually forwarded
    localparam logic [WB_ADR_WIDTH-1:0] ADR_STS_SELECT   = 8'h09;
    localparam logic [WB_ADR_WIDTH-1:0] ADR_CONFIG_NUM   = 8'h10;

    // identification
    localparam logic [WB_DAT_WIDTH-1:0] CORE_ID      = 32'h5a3c_0e21;
    localparam logic [WB_DAT_WIDTH-1:0] CORE_VERSION = 32'h0001_0000;

endpackage

`default_nettype wire

// ==== verilog/img_sel_pkg.sv ====
/*
 * Image side constants for the video source selector.
 * Sets the number of input streams and the widths of one raster beat.
 * RTL and testbench reach these by scoped names.
 */

`default_nettype none

package img_sel_pkg;

    // ------------------------------------------------------------------
    // stream count and source index
    // ------------------------------------------------------------------
    localparam int NUM       = 2;
    localparam int SEL_WIDTH = (NUM > 1) ? $clog2(NUM) : 1;

    // ------------------------------------------------------------------
    // beat payload
    // ------------------------------------------------------------------
    localparam int DATA_WIDTH = 24;
    localparam int USER_WIDTH = 1;

    // source in use right after reset
    localparam logic [SEL_WIDTH-1:0] INIT_SELECT = '0;

endpackage

`default_nettype wire
